// ==== flist.f ====
common/eeprom_pkg.sv
i2c_host/i2c_host.sv
eeprom/eeprom_array.sv
eeprom/eeprom_slave.sv
hdl/eeprom_subsys.sv
test/tb_clock.sv
test/eeprom_subsys_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f flist.f --top-module eeprom_subsys_tb \
    -Mdir obj_dir -o eeprom_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build returned status $status"
    exit $status
fi

./obj_dir/eeprom_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulator returned status $status"
    exit $status
fi

exit 0

// ==== test/eeprom_subsys_tb.sv ====
`default_nettype none

module eeprom_subsys_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import eeprom_pkg::*;

    localparam int ready_timeout = mem_depth + 64;
    localparam int done_timeout  = 2000;

    logic              scl;
    logic              rst;
    logic              cmd_write;
    logic              cmd_read;
    logic [addr_w-1:0] cmd_addr;
    logic [7:0]        cmd_wdata;
    logic              busy;
    logic              done;
    logic [7:0]        rdata;
    logic              ack_err;
    logic              ready;
    logic              bus_clk;
    logic              bus_dat;
    logic [7:0]        model_mem [mem_depth];

    tb_clock clk_gen_i (.clk(scl));

    eeprom_subsys dut_i (
        .scl       (scl),
        .rst       (rst),
        .cmd_write (cmd_write),
        .cmd_read  (cmd_read),
        .cmd_addr  (cmd_addr),
        .cmd_wdata (cmd_wdata),
        .busy      (busy),
        .done      (done),
        .rdata     (rdata),
        .ack_err   (ack_err),
        .ready     (ready),
        .bus_clk   (bus_clk),
        .bus_dat   (bus_dat)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string sig, input logic [7:0] got,
                                   input logic [7:0] exp);
        $display("ERR t=%0t %s got 0x%02h expected 0x%02h", $time, sig, got, exp);
        abort_run();
    endtask

    task automatic report_problem(input string what);
        $display("%s at t=%0t", what, $time);
        abort_run();
    endtask

    task automatic check_bit(input string sig, input logic got, input logic exp);
        assert (got === exp)
        else report_mismatch(sig, {7'b0, got}, {7'b0, exp});
    endtask

    task automatic check_byte(input string sig, input logic [7:0] got, input logic [7:0] exp);
        assert (got === exp)
        else report_mismatch(sig, got, exp);
    endtask

    task automatic drive_strobe(input logic wr, input logic [addr_w-1:0] a,
                                input logic [7:0] d);
        @(posedge scl);
        cmd_write <= wr;
        cmd_read  <= !wr;
        cmd_addr  <= a;
        cmd_wdata <= d;
        @(posedge scl);
        cmd_write <= 1'b0;
        cmd_read  <= 1'b0;
    endtask

    task automatic issue_cmd(input logic wr, input logic [addr_w-1:0] a, input logic [7:0] d);
        @(negedge scl);
        check_bit("ready", ready, 1'b1);
        check_bit("busy", busy, 1'b0);
        drive_strobe(wr, a, d);
        @(negedge scl);
        check_bit("busy", busy, 1'b1);
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (ready !== 1'b1)
        begin
            if (n == ready_timeout)
                report_problem("Timed out waiting for ready after reset");
            @(negedge scl);
            n++;
        end
    endtask

    task automatic wait_done(input string what);
        int n;
        n = 0;
        while (done !== 1'b1)
        begin
            if (n == done_timeout)
                report_problem($sformatf("Timed out waiting for done of the %s", what));
            @(negedge scl);
            n++;
        end
        check_bit("busy", busy, 1'b0);
        check_bit("ack_err", ack_err, 1'b0);
    endtask

    // Both lines must idle high after the stop, with no stray done
    task automatic check_idle_bus(input int cycles);
        repeat (cycles)
        begin
            @(negedge scl);
            check_bit("bus_clk", bus_clk, 1'b1);
            check_bit("bus_dat", bus_dat, 1'b1);
            check_bit("done", done, 1'b0);
            check_bit("busy", busy, 1'b0);
        end
    endtask

    task automatic run_write(input logic [addr_w-1:0] a, input logic [7:0] d);
        issue_cmd(1'b1, a, d);
        model_mem[a] = d;
        wait_done("write");
        check_idle_bus(6);
    endtask

    task automatic run_read(input logic [addr_w-1:0] a);
        issue_cmd(1'b0, a, 8'h00);
        wait_done("read");
        check_byte("rdata", rdata, model_mem[a]);
        check_idle_bus(6);
    endtask

    initial
    begin
        logic [31:0]       rng;
        logic [addr_w-1:0] addr;
        logic [addr_w-1:0] stray_a;
        logic [7:0]        stray_d;

        rst       = 1'b1;
        cmd_write = 1'b0;
        cmd_read  = 1'b0;
        cmd_addr  = '0;
        cmd_wdata = '0;
        rng       = 32'd39;
        for (int k = 0; k < mem_depth; k++)
            model_mem[k] = 8'h00;

        repeat (8) @(posedge scl);
        rst <= 1'b0;
        @(negedge scl);
        check_bit("busy", busy, 1'b0);
        check_bit("done", done, 1'b0);
        check_bit("ack_err", ack_err, 1'b0);
        check_bit("ready", ready, 1'b0);
        check_bit("bus_clk", bus_clk, 1'b1);
        check_bit("bus_dat", bus_dat, 1'b1);
        wait_ready();

        // Untouched locations read back as zero
        run_read(11'h7ff);
        run_read(11'h155);

        // One write and read back in every block
        for (int b = 0; b < 8; b++)
        begin
            rng  = lcg_step(rng);
            addr = {3'(b), rng[31:24]};
            run_write(addr, {rng[23:17], 1'b1});
            run_read(addr);
        end

        // Small address pool so overwrites happen
        for (int i = 0; i < 60; i++)
        begin
            rng  = lcg_step(rng);
            addr = {rng[23:21], 5'b01100, rng[20:18]};
            if (rng[17])
                run_write(addr, rng[31:24]);
            else
                run_read(addr);
        end

        stray_a = 11'h5c3;
        stray_d = ~model_mem[stray_a];
        issue_cmd(1'b1, 11'h0a7, 8'h3c);
        model_mem[11'h0a7] = 8'h3c;
        drive_strobe(1'b1, stray_a, stray_d);
        wait_done("write with a stray strobe");
        check_idle_bus(40);
        issue_cmd(1'b0, 11'h0a7, 8'h00);
        drive_strobe(1'b1, stray_a, stray_d);
        wait_done("read with a stray strobe");
        check_byte("rdata", rdata, model_mem[11'h0a7]);
        check_idle_bus(40);
        run_read(stray_a);

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
`default_nettype none

module tb_clock (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    // 8 ns period
    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== hdl/eeprom_subsys.sv ====
`default_nettype none

module eeprom_subsys (
    input  logic                          scl,
    input  logic                          rst,
    input  logic                          cmd_write,
    input  logic                          cmd_read,
    input  logic [eeprom_pkg::addr_w-1:0] cmd_addr,
    input  logic [7:0]                    cmd_wdata,
    output logic                          busy,
    output logic                          done,
    output logic [7:0]                    rdata,
    output logic                          ack_err,
    output logic                          ready,
    output logic                          bus_clk,
    output logic                          bus_dat
);
    import eeprom_pkg::*;

    logic              host_clk_low;
    logic              host_dat_low;
    logic              slave_dat_low;
    logic              mem_we;
    logic              mem_re;
    logic [addr_w-1:0] mem_addr;
    logic [7:0]        mem_wdata;
    logic [7:0]        mem_rdata;

    // Open-drain bus, either side may pull data low
    assign bus_clk = !host_clk_low;
    assign bus_dat = !(host_dat_low || slave_dat_low);

    i2c_host host_i (
        .scl          (scl),
        .rst          (rst),
        .ready        (ready),
        .cmd_write    (cmd_write),
        .cmd_read     (cmd_read),
        .cmd_addr     (cmd_addr),
        .cmd_wdata    (cmd_wdata),
        .bus_dat_in   (bus_dat),
        .host_clk_low (host_clk_low),
        .host_dat_low (host_dat_low),
        .busy         (busy),
        .done         (done),
        .rdata        (rdata),
        .ack_err      (ack_err)
    );

    eeprom_slave slave_i (
        .scl           (scl),
        .rst           (rst),
        .bus_clk_in    (bus_clk),
        .bus_dat_in    (bus_dat),
        .mem_rdata     (mem_rdata),
        .slave_dat_low (slave_dat_low),
        .mem_we        (mem_we),
        .mem_re        (mem_re),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata)
    );

    eeprom_array array_i (
        .scl       (scl),
        .rst       (rst),
        .mem_we    (mem_we),
        .mem_re    (mem_re),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .ready     (ready)
    );

endmodule

`default_nettype wire

// ==== eeprom/eeprom_slave.sv ====
`default_nettype none

module eeprom_slave (
    input  logic                          scl,
    input  logic                          rst,
    input  logic                          bus_clk_in,
    input  logic                          bus_dat_in,
    input  logic [7:0]                    mem_rdata,
    output logic                          slave_dat_low,
    output logic                          mem_we,
    output logic                          mem_re,
    output logic [eeprom_pkg::addr_w-1:0] mem_addr,
    output logic [7:0]                    mem_wdata
);
    import eeprom_pkg::*;

    slave_state_t state;
    slave_state_t after_ack;
    logic [2:0]   clk_s;
    logic [2:0]   dat_s;
    logic [3:0]   bit_cnt;
    logic [1:0]   start_cnt;
    logic [7:0]   sh;
    logic         clk_rise;
    logic         clk_fall;
    logic         start_c;
    logic         stop_c;
    logic         ctrl_ok;

    // Two synchronizer stages, the third holds the previous level
    always_ff @(posedge scl)
    begin
        if (rst)
        begin
            clk_s <= '1;
            dat_s <= '1;
        end
        else
        begin
            clk_s <= {clk_s[1:0], bus_clk_in};
            dat_s <= {dat_s[1:0], bus_dat_in};
        end
    end

    assign clk_rise = clk_s[1] && !clk_s[2];
    assign clk_fall = !clk_s[1] && clk_s[2];
    assign start_c  = clk_s[1] && clk_s[2] && dat_s[2] && !dat_s[1];
    assign stop_c   = clk_s[1] && clk_s[2] && !dat_s[2] && dat_s[1];

    // Write control after the first start, read control after a repeated start
    assign ctrl_ok = (sh[7:4] == dev_type)
                     && (sh[0] ? (start_cnt == 2'd2) : (start_cnt == 2'd1));

    always_ff @(posedge scl)
    begin
        if (rst)
        begin
            state         <= st_idle;
            after_ack     <= st_idle;
            bit_cnt       <= '0;
            start_cnt     <= '0;
            slave_dat_low <= 1'b0;
            mem_we        <= 1'b0;
            mem_re        <= 1'b0;
        end
        else
        begin
            mem_we <= 1'b0;
            mem_re <= 1'b0;
            if (stop_c)
            begin
                state         <= st_idle;
                start_cnt     <= '0;
                slave_dat_low <= 1'b0;
            end
            else if (start_c)
            begin
                state         <= st_ctrl;
                start_cnt     <= (state == st_idle) ? 2'd1 : 2'd2;
                bit_cnt       <= '0;
                slave_dat_low <= 1'b0;
            end
            else if (clk_rise)
            begin
                // Master acknowledge slot closes a read
                if (state == st_rdata && bit_cnt == 4'd8)
                    state <= st_idle;
                else if (state != st_idle && state != st_ack)
                    bit_cnt <= bit_cnt + 1'b1;
            end
            else if (clk_fall)
            begin
                case (state)
                    st_ctrl, st_addr, st_wdata:
                    begin
                        if (bit_cnt == 4'd8)
                        begin
                            if (state == st_ctrl && !ctrl_ok)
                                state <= st_idle;
                            else
                            begin
                                state         <= st_ack;
                                slave_dat_low <= 1'b1;
                                mem_we        <= (state == st_wdata);
                                mem_re        <= (state == st_ctrl) && sh[0];
                            end
                            case (state)
                                st_ctrl: after_ack <= sh[0] ? st_rdata : st_addr;
                                st_addr: after_ack <= st_wdata;
                                default: after_ack <= st_idle;
                            endcase
                        end
                    end
                    st_rdata:
                        slave_dat_low <= (bit_cnt != 4'd8) && !sh[6];
                    st_ack:
                    begin
                        state         <= after_ack;
                        bit_cnt       <= '0;
                        slave_dat_low <= (after_ack == st_rdata) && !mem_rdata[7];
                    end
                    default: ;
                endcase
            end
        end
    end

    // Shared shifter, in on rising edges and out on falling edges during a read
    always_ff @(posedge scl)
    begin
        if (clk_rise && state != st_rdata)
            sh <= {sh[6:0], dat_s[1]};
        if (clk_fall && state == st_ack && after_ack == st_rdata)
            sh <= mem_rdata;
        else if (clk_fall && state == st_rdata)
            sh <= {sh[6:0], 1'b0};

        if (clk_fall && bit_cnt == 4'd8)
        begin
            if (state == st_ctrl)
                mem_addr[addr_w-1:8] <= sh[3:1];
            if (state == st_addr)
                mem_addr[7:0] <= sh;
            if (state == st_wdata)
                mem_wdata <= sh;
        end
    end

    a_we_re_excl: assert property (@(posedge scl) disable iff (rst)
        !(mem_we && mem_re));

    a_idle_released: assert property (@(posedge scl) disable iff (rst)
        (state == st_idle) |-> !slave_dat_low);

endmodule

`default_nettype wire

// ==== eeprom/eeprom_array.sv ====
`default_nettype none

module eeprom_array (
    input  logic                          scl,
    input  logic                          rst,
    input  logic                          mem_we,
    input  logic                          mem_re,
    input  logic [eeprom_pkg::addr_w-1:0] mem_addr,
    input  logic [7:0]                    mem_wdata,
    output logic [7:0]                    mem_rdata,
    output logic                          ready
);
    import eeprom_pkg::*;

    logic [7:0]        mem [mem_depth];
    logic [addr_w-1:0] clr_addr;

    // Clear sweep, one location per cycle
    always_ff @(posedge scl)
    begin
        if (rst)
        begin
            clr_addr <= '0;
            ready    <= 1'b0;
        end
        else if (!ready)
        begin
            clr_addr <= clr_addr + 1'b1;
            if (clr_addr == addr_w'(mem_depth - 1))
                ready <= 1'b1;
        end
    end

    always_ff @(posedge scl)
    begin
        if (!ready)
            mem[clr_addr] <= 8'h00;
        else if (mem_we)
            mem[mem_addr] <= mem_wdata;
        if (ready && mem_re)
            mem_rdata <= mem[mem_addr];
    end

    a_we_after_ready: assert property (@(posedge scl) disable iff (rst)
        mem_we |-> ready);

endmodule

`default_nettype wire

// ==== i2c_host/i2c_host.sv ====
`default_nettype none

module i2c_host (
    input  logic                          scl,
    input  logic                          rst,
    input  logic                          ready,
    input  logic                          cmd_write,
    input  logic                          cmd_read,
    input  logic [eeprom_pkg::addr_w-1:0] cmd_addr,
    input  logic [7:0]                    cmd_wdata,
    input  logic                          bus_dat_in,
    output logic                          host_clk_low,
    output logic                          host_dat_low,
    output logic                          busy,
    output logic                          done,
    output logic [7:0]                    rdata,
    output logic                          ack_err
);
    import eeprom_pkg::*;

    typedef enum logic [1:0] {ph_idle, ph_start, ph_byte, ph_stop} phase_t;

    phase_t                            phase;
    logic [$clog2(quarter_cycles)-1:0] qcnt;
    logic [1:0]                        quarter;
    logic [3:0]                        bit_cnt;
    logic [1:0]                        byte_idx;
    logic                              is_read;
    logic [addr_w-1:0]                 addr_q;
    logic [7:0]                        wdata_q;
    logic [7:0]                        tx_sh;
    logic                              accept;
    logic                              tick;
    logic                              rx_byte;
    logic                              last_byte;
    logic                              dat_val;

    // Bytes of a transaction in bus order
    function automatic logic [7:0] byte_sel(input logic [1:0] idx);
        case (idx)
            2'd0:    return {dev_type, addr_q[addr_w-1:8], 1'b0};
            2'd1:    return addr_q[7:0];
            2'd2:    return is_read ? {dev_type, addr_q[addr_w-1:8], 1'b1} : wdata_q;
            default: return 8'hff;
        endcase
    endfunction

    assign accept    = ready && !busy && (cmd_write || cmd_read);
    assign tick      = (qcnt == $bits(qcnt)'(quarter_cycles - 1));
    assign rx_byte   = is_read && (byte_idx == 2'd3);
    assign last_byte = (byte_idx == (is_read ? 2'd3 : 2'd2));

    // Clock low for the first half of every bit slot
    assign host_clk_low = (phase != ph_idle) && !quarter[1];

    // Line level for quarters 1 and 2 of the current slot
    always_comb
    begin
        case (phase)
            ph_start: dat_val = 1'b0;
            ph_stop:  dat_val = 1'b1;
            ph_byte:  dat_val = (bit_cnt < 4'd8) && !rx_byte && !tx_sh[7];
            default:  dat_val = 1'b0;
        endcase
    end

    always_ff @(posedge scl)
    begin
        if (rst)
        begin
            phase        <= ph_idle;
            qcnt         <= '0;
            quarter      <= '0;
            bit_cnt      <= '0;
            byte_idx     <= '0;
            busy         <= 1'b0;
            done         <= 1'b0;
            ack_err      <= 1'b0;
            host_dat_low <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (accept)
            begin
                phase    <= ph_start;
                busy     <= 1'b1;
                ack_err  <= 1'b0;
                byte_idx <= '0;
            end
            else if (phase != ph_idle)
            begin
                qcnt <= tick ? '0 : qcnt + 1'b1;
                if (tick)
                begin
                    quarter <= quarter + 1'b1;
                    // Bits change with the clock low, start and stop edges with it high
                    if (quarter == 2'd0)
                        host_dat_low <= dat_val;
                    else if (quarter == 2'd2 && phase != ph_byte)
                        host_dat_low <= !dat_val;

                    // Missing acknowledge sampled as the clock rises
                    if (quarter == 2'd1 && phase == ph_byte && bit_cnt == 4'd8
                        && !rx_byte && bus_dat_in)
                        ack_err <= 1'b1;

                    if (quarter == 2'd3)
                    begin
                        case (phase)
                            ph_start:
                            begin
                                phase   <= ph_byte;
                                bit_cnt <= '0;
                            end
                            ph_byte:
                            begin
                                if (bit_cnt != 4'd8)
                                    bit_cnt <= bit_cnt + 1'b1;
                                else if (ack_err || last_byte)
                                    phase <= ph_stop;
                                else if (is_read && byte_idx == 2'd1)
                                begin
                                    phase    <= ph_start;
                                    byte_idx <= 2'd2;
                                end
                                else
                                begin
                                    byte_idx <= byte_idx + 1'b1;
                                    bit_cnt  <= '0;
                                end
                            end
                            ph_stop:
                            begin
                                phase <= ph_idle;
                                busy  <= 1'b0;
                                done  <= 1'b1;
                            end
                            default: phase <= ph_idle;
                        endcase
                    end
                end
            end
        end
    end

    // Latched command and the byte shifters
    always_ff @(posedge scl)
    begin
        if (accept)
        begin
            is_read <= !cmd_write;
            addr_q  <= cmd_addr;
            wdata_q <= cmd_wdata;
        end
        if (tick && phase == ph_byte)
        begin
            if (quarter == 2'd1 && rx_byte && bit_cnt < 4'd8)
                rdata <= {rdata[6:0], bus_dat_in};
            if (quarter == 2'd3)
                tx_sh <= (bit_cnt == 4'd8) ? byte_sel(byte_idx + 1'b1) : {tx_sh[6:0], 1'b1};
        end
        if (tick && quarter == 2'd3 && phase == ph_start)
            tx_sh <= byte_sel(byte_idx);
    end

    a_done_ends_txn: assert property (@(posedge scl) disable iff (rst)
        done |-> $past(busy));

    // Data only moves under a high clock to form start or stop
    a_dat_stable: assert property (@(posedge scl) disable iff (rst)
        (!host_clk_low && $past(!host_clk_low) && phase inside {ph_idle, ph_byte})
        |-> $stable(host_dat_low));

endmodule

`default_nettype wire

// ==== common/eeprom_pkg.sv ====
`default_nettype none

package eeprom_pkg;

    // Device type code in the top nibble of every control byte
    localparam logic [3:0] dev_type = 4'b1010;

    // Byte address, top three bits ride in the control byte
    localparam int addr_w = 11;

    localparam int mem_depth = 2048;

    // System clock cycles per quarter of a bus bit
    localparam int quarter_cycles = 4;

    typedef enum logic [2:0] {
        st_idle,
        st_ctrl,
        st_addr,
        st_wdata,
        st_rdata,
        st_ack
    } slave_state_t;

endpackage

`default_nettype wire
